// ==== include/vsa_defines.svh ====
// ************************************************
// VSA width and depth macros
// ************************************************
`ifndef VSA_DEFINES_SVH
`define VSA_DEFINES_SVH

// register and data memory word
`define VSA_DATA_WIDTH 5
// program counter, 32 instruction words
`define VSA_PC_WIDTH 5
// R-format and I-format are both 12 bits
`define VSA_INSTR_WIDTH 12
// data memory words
`define VSA_MEM_DEPTH 32
// R0..R3, R0 hardwired to zero
`define VSA_NUM_REGS 4

`endif

// ==== src/vsaIsaPkg.sv ====
// ************************************************
// VSA instruction set types
// ************************************************
`include "vsa_defines.svh"

package vsaIsaPkg;

    typedef logic [`VSA_DATA_WIDTH-1:0] dataT;  // register / memory word
    typedef logic [1:0] regAddrT;               // R0..R3

    // major opcode, top three instruction bits
    typedef enum logic [2:0] {
        LW    = 3'd0,   // load word
        SW    = 3'd1,   // store word
        BEQZ  = 3'd2,   // branch if src1 zero
        ALUOP = 3'd3,   // reg-reg, func field selects op
        ADDI  = 3'd4,
        SUBI  = 3'd5
    } opcodeT;

    // reg-reg function codes
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        NOT = 3'd5,     // src1 only
        SRL = 3'd6,     // shift by one
        SRA = 3'd7
    } aluFuncT;

    typedef struct packed {
        regAddrT src1;
        regAddrT src2;
        regAddrT dst;
        aluFuncT func;
    } rFmtT;

    // dst shares the src2 slot of R-format
    typedef struct packed {
        regAddrT src1;
        regAddrT dst;
        dataT    imm;   // zero-extended
    } iFmtT;

    typedef union packed {
        rFmtT r;
        iFmtT i;
    } instrBodyT;

    typedef struct packed {
        opcodeT    opcode;
        instrBodyT body;
    } instrT;

endpackage

// ==== src/vsaCtrlPkg.sv ====
// ************************************************
// VSA sequencer and decode types
// ************************************************

package vsaCtrlPkg;

    // one state per clock of an instruction
    typedef enum logic [2:0] {
        IF  = 3'd0,     // fetch, IR and NPC load
        ID  = 3'd1,     // operand latch
        EX  = 3'd2,     // ALU result, branch condition
        MEM = 3'd3,     // load / store, pc update
        WB  = 3'd4      // register write
    } cpuStateT;

    // decoded instruction class, one hot for legal opcodes
    typedef struct packed {
        logic memRef;       // LW or SW
        logic regRegAlu;    // ALUOP
        logic regImmAlu;    // ADDI or SUBI
        logic branch;       // BEQZ
    } instrClassT;

endpackage

// ==== src/vsaDataBusIf.sv ====
// ************************************************
// VSA data memory bus
// ************************************************
`timescale 1ns/100ps

interface vsaDataBusIf;
    import vsaIsaPkg::*;

    dataT addr;     // from core ALU output register
    dataT wrData;   // operand B
    logic wr;       // one cycle, MEM state of SW
    dataT rdData;   // combinational from addr

    // core side
    modport core (
        output addr,
        output wrData,
        output wr,
        input  rdData
    );

    // memory side
    modport mem (
        input  addr,
        input  wrData,
        input  wr,
        output rdData
    );

endinterface

// ==== src/vsaRegFile.sv ====
// ************************************************
// VSA register file
// ************************************************
`timescale 1ns/100ps
`include "vsa_defines.svh"

module vsaRegFile (
    input  logic               clock,
    input  logic               rstN,
    input  vsaIsaPkg::regAddrT rdAddrA,    // src1
    input  vsaIsaPkg::regAddrT rdAddrB,    // src2
    output vsaIsaPkg::dataT    rdDataA,
    output vsaIsaPkg::dataT    rdDataB,
    input  logic               wrEn,       // WB of a writing instruction
    input  vsaIsaPkg::regAddrT wrAddr,
    input  vsaIsaPkg::dataT    wrData
);
    import vsaIsaPkg::*;

    // only R1..R3 are stored
    dataT regs [1:`VSA_NUM_REGS-1];

    // R0 reads zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `VSA_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin   // R0 writes dropped
            regs[wrAddr] <= wrData;
        end
    end

    // a register written in WB reads back the new value on the next cycle
    readAfterWrite: assert property (@(posedge clock) disable iff (!rstN)
        (wrEn && wrAddr != '0) ##1 (rdAddrA == $past(wrAddr))
        |-> rdDataA == $past(wrData))
        else $error("register read back differs from the value written");

endmodule

// ==== src/vsaAlu.sv ====
// ************************************************
// VSA ALU and branch unit
// ************************************************
`timescale 1ns/100ps
`include "vsa_defines.svh"

module vsaAlu (
    input  vsaIsaPkg::dataT         opA,    // latched src1
    input  vsaIsaPkg::dataT         opB,    // latched src2
    input  vsaIsaPkg::dataT         imm,    // I-format immediate
    input  logic [`VSA_PC_WIDTH-1:0] npc,   // pc + 2
    input  vsaIsaPkg::opcodeT       opcode,
    input  vsaIsaPkg::aluFuncT      func,
    input  vsaCtrlPkg::instrClassT  cls,
    output vsaIsaPkg::dataT         result,
    output logic                    isZero  // BEQZ condition
);
    import vsaIsaPkg::*;

    assign isZero = (opA == '0);

    always_comb begin
        result = '0;                        // unused opcodes give zero
        if (cls.memRef) begin
            result = opA + imm;             // effective address
        end else if (cls.regRegAlu) begin
            case (func)
                ADD: result = opA + opB;
                SUB: result = opA - opB;
                AND: result = opA & opB;
                OR:  result = opA | opB;
                XOR: result = opA ^ opB;
                NOT: result = ~opA;
                SRL: result = {1'b0, opA[`VSA_DATA_WIDTH-1:1]};
                SRA: result = dataT'($signed(opA) >>> 1);   // sign bit kept
                default: result = '0;
            endcase
        end else if (cls.regImmAlu) begin
            // wraps at word width with imm zero-extended
            if (opcode == SUBI) begin
                result = opA - imm;
            end else begin
                result = opA + imm;
            end
        end else if (cls.branch) begin
            // low four imm bits as a doubled word offset
            result = npc + {imm[3:0], 1'b0};
        end
    end

endmodule

// ==== src/vsaCore.sv ====
// ************************************************
// VSA multicycle core
// ************************************************
`timescale 1ns/100ps
`include "vsa_defines.svh"

module vsaCore (
    input  logic                     clock,
    input  logic                     rstN,
    output logic [`VSA_PC_WIDTH-1:0] pc,            // instruction address
    input  vsaIsaPkg::instrT         instruction,   // must be valid in IF
    vsaDataBusIf.core                dBus
);
    import vsaIsaPkg::*;
    import vsaCtrlPkg::*;

    localparam logic [`VSA_PC_WIDTH-1:0] pcStep = 2;   // instruction stride

    cpuStateT state;
    instrT    ir;                       // instruction register
    logic [`VSA_PC_WIDTH-1:0] npc;      // next pc
    dataT     a;                        // first ALU operand
    dataT     b;                        // second operand and store data
    dataT     aluOut;                   // ALU output register
    logic     cond;                     // branch taken
    dataT     lmd;                      // load data

    opcodeT     opcode;
    instrClassT cls;
    dataT       rdDataA;
    dataT       rdDataB;
    dataT       aluResult;
    logic       aluZero;
    logic       rfWrEn;
    regAddrT    rfWrAddr;
    dataT       rfWrData;

    assign opcode = ir.opcode;

    // instruction class decode
    always_comb begin
        cls.memRef    = (opcode == LW) || (opcode == SW);
        cls.regRegAlu = (opcode == ALUOP);
        cls.regImmAlu = (opcode == ADDI) || (opcode == SUBI);
        cls.branch    = (opcode == BEQZ);
    end

    // write-back source and destination
    assign rfWrEn   = (state == WB) && (cls.regRegAlu || cls.regImmAlu || opcode == LW);
    assign rfWrAddr = cls.regRegAlu ? ir.body.r.dst : ir.body.i.dst;
    assign rfWrData = (opcode == LW) ? lmd : aluOut;

    // data bus
    assign dBus.addr   = aluOut;
    assign dBus.wrData = b;
    assign dBus.wr     = (state == MEM) && (opcode == SW);   // single store strobe

    vsaRegFile regFileInst (
        .clock   (clock),
        .rstN    (rstN),
        .rdAddrA (ir.body.r.src1),
        .rdAddrB (ir.body.r.src2),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (rfWrEn),
        .wrAddr  (rfWrAddr),
        .wrData  (rfWrData)
    );

    vsaAlu aluInst (
        .opA    (a),
        .opB    (b),
        .imm    (ir.body.i.imm),
        .npc    (npc),
        .opcode (opcode),
        .func   (ir.body.r.func),
        .cls    (cls),
        .result (aluResult),
        .isZero (aluZero)
    );

    // five-state sequencer wrapping from WB to IF
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= IF;
        end else begin
            case (state)
                WB:      state <= IF;
                default: state <= cpuStateT'(state + 3'd1);
            endcase
        end
    end

    // control registers
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc   <= '0;
            ir   <= '0;
            cond <= 1'b0;
        end else begin
            if (state == IF) begin
                ir <= instruction;
            end
            if (state == EX && cls.branch) begin
                cond <= aluZero;
            end
            if (state == MEM) begin
                pc <= (cls.branch && cond) ? aluOut : npc;   // new pc at end of MEM
            end
        end
    end

    // datapath latches
    always_ff @(posedge clock) begin
        case (state)
            IF: npc <= pc + pcStep;
            ID: begin
                a <= rdDataA;
                b <= rdDataB;
            end
            EX: aluOut <= aluResult;
            MEM: begin
                if (opcode == LW) begin
                    lmd <= dBus.rdData;     // async memory read
                end
            end
            default: ;
        endcase
    end

    // sequencer stays on the five legal states
    stateLegal: assert property (@(posedge clock) disable iff (!rstN)
        state inside {IF, ID, EX, MEM, WB})
        else $error("illegal state %0d", state);

    // single-cycle store strobe in the fourth cycle after fetch
    storeStrobe: assert property (@(posedge clock) disable iff (!rstN)
        dBus.wr |-> ($past(state, 3) == IF) ##1 !dBus.wr)
        else $error("store strobe outside the fourth instruction cycle");

endmodule

// ==== src/vsaDataMem.sv ====
// ************************************************
// VSA data memory
// ************************************************
`timescale 1ns/100ps
`include "vsa_defines.svh"

module vsaDataMem (
    input logic      clock,
    vsaDataBusIf.mem bus
);
    import vsaIsaPkg::*;

    // 32 words, contents undefined until stored
    dataT mem [`VSA_MEM_DEPTH];

    // read is combinational from the address
    assign bus.rdData = mem[bus.addr];

    // write on the edge ending MEM of a store
    always_ff @(posedge clock) begin
        if (bus.wr) begin
            mem[bus.addr] <= bus.wrData;
        end
    end

endmodule

// ==== src/vsaSystem.sv ====
// ************************************************
// VSA processor subsystem top
// ************************************************
`timescale 1ns/100ps
`include "vsa_defines.svh"

module vsaSystem (
    input  logic                        clock,
    input  logic                        rstN,
    output logic [`VSA_PC_WIDTH-1:0]    pc,             // to external instruction memory
    input  logic [`VSA_INSTR_WIDTH-1:0] instruction,
    output logic                        storeValid,     // bus wr
    output logic [`VSA_DATA_WIDTH-1:0]  storeAddr,
    output logic [`VSA_DATA_WIDTH-1:0]  storeData
);

    vsaDataBusIf dataBus ();

    vsaCore coreInst (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .dBus        (dataBus.core)
    );

    vsaDataMem memInst (
        .clock (clock),
        .bus   (dataBus.mem)
    );

    // store path visible outside
    assign storeValid = dataBus.wr;
    assign storeAddr  = dataBus.addr;
    assign storeData  = dataBus.wrData;

endmodule

// ==== sim/vsaSystemTb.sv ====
// ************************************************
// VSA subsystem testbench
// ************************************************
`timescale 1ns/100ps
`include "vsa_defines.svh"

module vsaSystemTb;
    import vsaIsaPkg::*;

    localparam int clockPeriod  = 40;
    localparam int driveDelay   = 2;    // after rising edge
    localparam int numPrograms  = 4;    // two ALU functions each
    localparam int instrPerProg = 24;   // one and a half passes of 16 slots
    localparam int timeoutNs    =
        (numPrograms * (instrPerProg * 5 + 3) + 50) * clockPeriod;

    logic                        clock;
    logic                        rstN;
    logic [`VSA_PC_WIDTH-1:0]    pc;
    logic [`VSA_INSTR_WIDTH-1:0] instruction;
    logic                        storeValid;
    logic [`VSA_DATA_WIDTH-1:0]  storeAddr;
    logic [`VSA_DATA_WIDTH-1:0]  storeData;

    logic [`VSA_INSTR_WIDTH-1:0] rom [1 << `VSA_PC_WIDTH];   // program ROM
    logic [31:0] lcgState;

    // instruction-level model
    dataT    mRegs [`VSA_NUM_REGS];
    dataT    dmem [`VSA_MEM_DEPTH];     // undefined until stored
    logic [`VSA_PC_WIDTH-1:0] mPc;
    logic [2:0] phase;                  // 0..4 follows IF..WB
    logic    eValid;                    // current instruction stores
    dataT    eAddr;
    dataT    eData;
    logic [`VSA_PC_WIDTH-1:0] eNextPc;
    logic    eWrEn;
    regAddrT eWrAddr;
    dataT    eWrData;
    logic [`VSA_PC_WIDTH-1:0] expPc;
    logic    expValid;

    int instrCount;                     // per program
    int totalInstr;
    int storesExpected;
    int storesSeen;
    int errors;

    vsaSystem dut_i (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    function automatic logic [4:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[20:16];             // upper bits mix better
    endfunction

    function automatic logic [11:0] encodeReg(regAddrT s1, regAddrT s2, regAddrT d,
                                              aluFuncT fn);
        return {ALUOP, s1, s2, d, fn};
    endfunction

    // SW puts its data register in the dst slot
    function automatic logic [11:0] encodeImm(opcodeT op, regAddrT s1, regAddrT d,
                                              logic [4:0] imm);
        return {op, s1, d, imm};
    endfunction

    task automatic buildProgram(input int p);
        int i;
        logic [4:0] r;
        for (i = 0; i < (1 << `VSA_PC_WIDTH); i++) begin
            rom[i] = {SW, 4'b0000, 5'(i)};  // stray fetch shows up as a store
        end
        rom[0]  = encodeImm(ADDI, 2'd0, 2'd1, nextRandom());
        rom[2]  = encodeImm(ADDI, 2'd0, 2'd2, nextRandom());
        rom[4]  = encodeReg(2'd1, 2'd2, 2'd3, aluFuncT'(2 * p));
        rom[6]  = encodeImm(SW, 2'd0, 2'd3, 5'd4);
        rom[8]  = encodeReg(2'd2, 2'd1, 2'd3, aluFuncT'(2 * p + 1));
        rom[10] = encodeImm(SW, 2'd0, 2'd3, 5'd5);
        rom[12] = encodeImm(SUBI, 2'd1, 2'd1, nextRandom());   // wraps below zero
        rom[14] = encodeImm(LW, 2'd0, 2'd2, 5'd4);
        r = nextRandom();
        rom[16] = encodeReg(2'd2, 2'd1, 2'd3, aluFuncT'(r[2:0]));
        rom[18] = encodeImm(SW, 2'd1, 2'd3, nextRandom());     // SUBI result as base
        rom[20] = encodeImm(ADDI, 2'd1, 2'd0, nextRandom());   // dropped R0 write
        rom[22] = encodeImm(SW, 2'd0, 2'd0, 5'd6);
        rom[24] = encodeImm(BEQZ, 2'd0, 2'd0, 5'd1);           // always taken to 28
        rom[26] = encodeImm(SW, 2'd0, 2'd2, 5'd8);             // skipped
        rom[28] = encodeImm(BEQZ, 2'd1, 2'd0, nextRandom());
        rom[30] = encodeImm(SW, 2'd0, 2'd2, 5'd7);             // loaded word
    endtask

    // expected effects of the word at mPc
    task automatic predictInstr();
        logic [11:0] w;
        logic [2:0]  op;
        logic [2:0]  fn;
        logic [4:0]  imm;
        dataT        a;
        dataT        b;
        w   = rom[mPc];
        op  = w[11:9];
        fn  = w[2:0];
        imm = w[4:0];
        a   = mRegs[w[8:7]];
        b   = mRegs[w[6:5]];
        eValid  = 1'b0;
        eAddr   = '0;
        eData   = '0;
        eWrEn   = 1'b0;
        eWrAddr = w[6:5];                   // I-format dst
        eWrData = '0;
        eNextPc = mPc + 5'd2;
        case (op)
            LW: begin
                eWrEn   = 1'b1;
                eWrData = dmem[5'(a + imm)];
            end
            SW: begin
                eValid = 1'b1;
                eAddr  = a + imm;
                eData  = b;
            end
            BEQZ: begin
                if (a == '0) begin
                    eNextPc = mPc + 5'd2 + {imm[3:0], 1'b0};
                end
            end
            ALUOP: begin
                eWrEn   = 1'b1;
                eWrAddr = w[4:3];           // R-format dst
                case (fn)
                    ADD:     eWrData = a + b;
                    SUB:     eWrData = a - b;
                    AND:     eWrData = a & b;
                    OR:      eWrData = a | b;
                    XOR:     eWrData = a ^ b;
                    NOT:     eWrData = ~a;
                    SRL:     eWrData = {1'b0, a[4:1]};
                    default: eWrData = {a[4], a[4:1]};  // SRA
                endcase
            end
            ADDI: begin
                eWrEn   = 1'b1;
                eWrData = a + imm;
            end
            SUBI: begin
                eWrEn   = 1'b1;
                eWrData = a - imm;
            end
            default: ;
        endcase
    endtask

    task automatic commitInstr();
        if (eWrEn && eWrAddr != '0) begin
            mRegs[eWrAddr] = eWrData;
        end
        if (eValid) begin
            dmem[eAddr] = eData;
            storesExpected++;
        end
        mPc = eNextPc;
        instrCount++;
        totalInstr++;
    endtask

    // model steps once per five cycles
    always @(posedge clock) begin
        if (!rstN) begin
            phase      = 3'd0;
            mPc        = '0;
            instrCount = 0;
            mRegs      = '{default: '0};
            predictInstr();
        end else if (phase == 3'd4) begin
            commitInstr();
            phase = 3'd0;
            predictInstr();
        end else begin
            phase = phase + 3'd1;
        end
    end

    assign expPc    = (phase == 3'd4) ? eNextPc : mPc;   // new pc shows in WB
    assign expValid = (phase == 3'd3) && eValid;

    // instruction word for the current pc
    always @(posedge clock) begin
        #driveDelay;
        instruction = rom[pc];
    end

    always @(negedge clock) begin
        if (rstN && storeValid) begin
            storesSeen++;
        end
    end

    pcCheck: assert property (@(posedge clock) disable iff (!rstN) pc == expPc)
        else begin
            errors++;
            $display("Error pc expected %h actual %h", $sampled(expPc), $sampled(pc));
        end

    validCheck: assert property (@(posedge clock) disable iff (!rstN)
        storeValid == expValid)
        else begin
            errors++;
            $display("Error storeValid expected %h actual %h",
                     $sampled(expValid), $sampled(storeValid));
        end

    addrCheck: assert property (@(posedge clock) disable iff (!rstN)
        storeValid |-> storeAddr == eAddr)
        else begin
            errors++;
            $display("Error storeAddr expected %h actual %h",
                     $sampled(eAddr), $sampled(storeAddr));
        end

    dataCheck: assert property (@(posedge clock) disable iff (!rstN)
        storeValid |-> storeData == eData)
        else begin
            errors++;
            $display("Error storeData expected %h actual %h",
                     $sampled(eData), $sampled(storeData));
        end

    initial begin
        #timeoutNs;
        $display("timeout: the programs did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rstN           = 1'b0;
        instruction    = '0;
        lcgState       = 32'd2805;
        totalInstr     = 0;
        storesExpected = 0;
        storesSeen     = 0;
        errors         = 0;
        for (int p = 0; p < numPrograms; p++) begin
            buildProgram(p);
            rstN = 1'b0;
            repeat (2) @(posedge clock);
            #driveDelay rstN = 1'b1;
            while (instrCount < instrPerProg) begin
                @(posedge clock);
                #driveDelay;
            end
        end
        if (storesSeen != storesExpected) begin
            errors++;
            $display("Error store count expected %h actual %h", storesExpected, storesSeen);
        end
        $display("instructions %0d  stores %0d  errors %0d", totalInstr, storesSeen, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vsaSystem.f ====
+incdir+include
src/vsaIsaPkg.sv
src/vsaCtrlPkg.sv
src/vsaDataBusIf.sv
src/vsaRegFile.sv
src/vsaAlu.sv
src/vsaCore.sv
src/vsaDataMem.sv
src/vsaSystem.sv
sim/vsaSystemTb.sv
